// ==== logic/core_pkg.sv ====
package core_pkg;

    localparam int word_w = 16;
    localparam int reg_idx_w = 4;
    localparam int insn_w = 32;
    localparam int pc_w = 8;
    localparam int addr_w = 8;
    localparam int opcode_w = 4;

    localparam logic [opcode_w-1:0] op_nop = 4'h0;
    localparam logic [opcode_w-1:0] op_halt = 4'h1;
    localparam logic [opcode_w-1:0] op_add = 4'h2;
    localparam logic [opcode_w-1:0] op_sub = 4'h3;
    localparam logic [opcode_w-1:0] op_mul = 4'h4;
    localparam logic [opcode_w-1:0] op_and = 4'h5;
    localparam logic [opcode_w-1:0] op_or = 4'h6;
    localparam logic [opcode_w-1:0] op_xor = 4'h7;
    localparam logic [opcode_w-1:0] op_shl = 4'h8;
    localparam logic [opcode_w-1:0] op_shr = 4'h9;
    localparam logic [opcode_w-1:0] op_cmpge = 4'ha;
    localparam logic [opcode_w-1:0] op_ld = 4'hb;
    localparam logic [opcode_w-1:0] op_st = 4'hc;
    localparam logic [opcode_w-1:0] op_setc = 4'hd;
    localparam logic [opcode_w-1:0] op_setid = 4'he;
    localparam logic [opcode_w-1:0] op_bnz = 4'hf;

    // lsb of each field in the instruction word
    localparam int opc_lsb = 28;
    localparam int dst_lsb = 24;
    localparam int src0_lsb = 20;
    localparam int src1_lsb = 16;
    localparam int src2_lsb = 12;
    localparam int konst_lsb = 0;
    localparam int target_lsb = 0;

    localparam logic [insn_w-1:0] nop_insn = '0;
    localparam logic [insn_w-1:0] halt_insn = {op_halt, {(insn_w - opcode_w){1'b0}}};

    // data memory request codes
    localparam logic [1:0] mem_ld = 2'b01;
    localparam logic [1:0] mem_st = 2'b10;

    // operand source in execute
    localparam logic [1:0] fwd_none = 2'd0;
    localparam logic [1:0] fwd_mem = 2'd1;
    localparam logic [1:0] fwd_wb = 2'd2;

    function automatic logic reads_src1(input logic [opcode_w-1:0] op);
        return op inside {op_add, op_sub, op_mul, op_and, op_or, op_xor,
                          op_shl, op_shr, op_cmpge};
    endfunction

    function automatic logic writes_reg(input logic [opcode_w-1:0] op);
        return reads_src1(op) || (op inside {op_ld, op_setc, op_setid});
    endfunction

    function automatic logic is_mem_op(input logic [opcode_w-1:0] op);
        return (op == op_ld) || (op == op_st);
    endfunction

endpackage

// ==== logic/insn_memory.sv ====
`timescale 1ns/10ps

module insn_memory (
    input  logic                         clk,
    input  logic                         wr,
    input  logic [core_pkg::pc_w-1:0]    wr_addr,
    input  logic [core_pkg::insn_w-1:0]  wr_data,
    input  logic [core_pkg::pc_w-1:0]    rd_addr,
    output logic [core_pkg::insn_w-1:0]  rd_data
);
    import core_pkg::*;

    logic [insn_w-1:0] mem [2**pc_w];

    always_ff @(posedge clk)
    begin
        if (wr)
            mem[wr_addr] <= wr_data;  // host load only
    end

    // fetch reads in the same cycle
    assign rd_data = mem[rd_addr];

endmodule

// ==== logic/register_file.sv ====
`timescale 1ns/10ps

module register_file (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           init_r0,
    input  logic [core_pkg::word_w-1:0]    init_r0_data,
    input  logic [core_pkg::reg_idx_w-1:0] rd_idx0,
    input  logic [core_pkg::reg_idx_w-1:0] rd_idx1,
    input  logic [core_pkg::reg_idx_w-1:0] rd_idx2,
    output logic [core_pkg::word_w-1:0]    rd_data0,
    output logic [core_pkg::word_w-1:0]    rd_data1,
    output logic [core_pkg::word_w-1:0]    rd_data2,
    input  logic                           wr_en,
    input  logic [core_pkg::reg_idx_w-1:0] wr_idx,
    input  logic [core_pkg::word_w-1:0]    wr_data
);
    import core_pkg::*;

    logic [word_w-1:0] regs [2**reg_idx_w];

    // a same-cycle write is visible to decode
    function automatic logic [word_w-1:0] read_port(input logic [reg_idx_w-1:0] idx);
        return (wr_en && wr_idx == idx) ? wr_data : regs[idx];
    endfunction

    always_comb
    begin
        rd_data0 = read_port(rd_idx0);
        rd_data1 = read_port(rd_idx1);
        rd_data2 = read_port(rd_idx2);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 2**reg_idx_w; i++)
                regs[i] <= '0;
        end
        else if (init_r0)
            regs[0] <= init_r0_data;
        else if (wr_en)
            regs[wr_idx] <= wr_data;
    end

    // host init only happens while the pipeline is idle
    a_init_vs_wb: assert property (@(posedge clk) disable iff (reset) !(init_r0 && wr_en));

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/10ps

module alu #(
    parameter logic [7:0] core_id = 8'd0
) (
    input  logic [core_pkg::opcode_w-1:0] opcode,
    input  logic [core_pkg::word_w-1:0]   a,
    input  logic [core_pkg::word_w-1:0]   b,
    input  logic [core_pkg::word_w-1:0]   konst,
    output logic [core_pkg::word_w-1:0]   result,
    output logic                          nonzero
);
    import core_pkg::*;

    localparam int sh_w = $clog2(word_w);

    always_comb
    begin
        case (opcode)
            op_add:   result = a + b;
            op_sub:   result = a - b;
            op_mul:   result = a * b;  // low half only
            op_and:   result = a & b;
            op_or:    result = a | b;
            op_xor:   result = a ^ b;
            op_shl:   result = a << b[sh_w-1:0];
            op_shr:   result = a >> b[sh_w-1:0];
            op_cmpge: result = (a >= b) ? word_w'(1) : '0;  // unsigned
            op_ld,
            op_st:    result = a + konst;  // effective address
            op_setc:  result = konst;
            op_setid: result = word_w'(core_id);
            default:  result = '0;
        endcase
    end

    // bnz condition, qualified by opcode in the core
    assign nonzero = |a;

endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/10ps

module hazard_unit (
    input  logic [core_pkg::insn_w-1:0] dec_insn,
    input  logic [core_pkg::insn_w-1:0] ex_insn,
    input  logic [core_pkg::insn_w-1:0] mem_insn,
    input  logic [core_pkg::insn_w-1:0] wb_insn,
    output logic                        stall,
    output logic [1:0]                  fwd_sel0,
    output logic [1:0]                  fwd_sel1,
    output logic [1:0]                  fwd_sel2
);
    import core_pkg::*;

    logic [opcode_w-1:0] dec_op;
    logic [opcode_w-1:0] ex_op;
    logic [opcode_w-1:0] mem_op;
    logic [opcode_w-1:0] wb_op;
    logic [reg_idx_w-1:0] ex_dst;
    logic [reg_idx_w-1:0] mem_dst;
    logic [reg_idx_w-1:0] wb_dst;
    logic dec_reads0;
    logic dec_reads2;
    logic mem_fwd;
    logic wb_fwd;

    assign dec_op = dec_insn[opc_lsb +: opcode_w];
    assign ex_op = ex_insn[opc_lsb +: opcode_w];
    assign mem_op = mem_insn[opc_lsb +: opcode_w];
    assign wb_op = wb_insn[opc_lsb +: opcode_w];
    assign ex_dst = ex_insn[dst_lsb +: reg_idx_w];
    assign mem_dst = mem_insn[dst_lsb +: reg_idx_w];
    assign wb_dst = wb_insn[dst_lsb +: reg_idx_w];

    assign dec_reads0 = reads_src1(dec_op) || is_mem_op(dec_op) || dec_op == op_bnz;
    assign dec_reads2 = dec_op == op_st;  // store data

    // load result is not ready until writeback
    assign stall = ex_op == op_ld
        && ((dec_reads0 && dec_insn[src0_lsb +: reg_idx_w] == ex_dst)
        || (reads_src1(dec_op) && dec_insn[src1_lsb +: reg_idx_w] == ex_dst)
        || (dec_reads2 && dec_insn[src2_lsb +: reg_idx_w] == ex_dst));

    assign mem_fwd = writes_reg(mem_op) && mem_op != op_ld;
    assign wb_fwd = writes_reg(wb_op);

    function automatic logic [1:0] sel_for(input logic [reg_idx_w-1:0] idx);
        if (mem_fwd && mem_dst == idx)
            return fwd_mem;  // younger result wins
        if (wb_fwd && wb_dst == idx)
            return fwd_wb;
        return fwd_none;
    endfunction

    always_comb
    begin
        fwd_sel0 = sel_for(ex_insn[src0_lsb +: reg_idx_w]);
        fwd_sel1 = sel_for(ex_insn[src1_lsb +: reg_idx_w]);
        fwd_sel2 = sel_for(ex_insn[src2_lsb +: reg_idx_w]);
        // fetch stops behind a halt, so nothing younger can stall
        a_no_stall_at_halt: assert final (!(stall && mem_op == op_halt));
    end

endmodule

// ==== logic/core.sv ====
`timescale 1ns/10ps

module core #(
    parameter logic [7:0] core_id = 8'd0
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          insn_wr,
    input  logic [core_pkg::pc_w-1:0]     insn_wr_addr,
    input  logic [core_pkg::insn_w-1:0]   insn_wr_data,
    input  logic                          init_r0_flag,
    input  logic [core_pkg::word_w-1:0]   init_r0_data,
    input  logic                          start,
    output logic                          ready,
    output logic [1:0]                    mem_en,
    output logic [core_pkg::addr_w-1:0]   mem_addr,
    output logic [core_pkg::word_w-1:0]   mem_wdata,
    input  logic [core_pkg::word_w-1:0]   mem_rdata,
    input  logic                          mem_ready
);
    import core_pkg::*;

    logic [pc_w:0] pc;  // top bit set once past the last address
    logic ready_r;
    logic [insn_w-1:0] fd_insn;
    logic [insn_w-1:0] dx_insn;
    logic [insn_w-1:0] xm_insn;
    logic [insn_w-1:0] mw_insn;
    logic [word_w-1:0] dx_a;
    logic [word_w-1:0] dx_b;
    logic [word_w-1:0] dx_c;
    logic [word_w-1:0] xm_result;
    logic [word_w-1:0] xm_wdata;
    logic [word_w-1:0] mw_value;

    logic [insn_w-1:0] imem_data;
    logic [insn_w-1:0] fetch_insn;
    logic [word_w-1:0] rf_a;
    logic [word_w-1:0] rf_b;
    logic [word_w-1:0] rf_c;
    logic [word_w-1:0] ex_a;
    logic [word_w-1:0] ex_b;
    logic [word_w-1:0] ex_c;
    logic [word_w-1:0] alu_result;
    logic [1:0] fwd_sel0;
    logic [1:0] fwd_sel1;
    logic [1:0] fwd_sel2;
    logic stall;
    logic alu_nonzero;

    wire [opcode_w-1:0] fd_op = fd_insn[opc_lsb +: opcode_w];
    wire [opcode_w-1:0] ex_op = dx_insn[opc_lsb +: opcode_w];
    wire [opcode_w-1:0] xm_op = xm_insn[opc_lsb +: opcode_w];
    wire [opcode_w-1:0] mw_op = mw_insn[opc_lsb +: opcode_w];

    wire launch = start && ready_r;
    wire freeze = ready_r || (is_mem_op(xm_op) && !mem_ready);
    wire halt_done = xm_op == op_halt && !freeze;
    wire take_branch = ex_op == op_bnz && alu_nonzero;
    wire halt_seen = fd_op == op_halt || ex_op == op_halt || xm_op == op_halt;

    function automatic logic [word_w-1:0] fwd_mux(input logic [1:0] sel,
                                                  input logic [word_w-1:0] reg_val,
                                                  input logic [word_w-1:0] mem_val,
                                                  input logic [word_w-1:0] wb_val);
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    insn_memory u_insn_memory (
        .clk     (clk),
        .wr      (insn_wr && ready_r),
        .wr_addr (insn_wr_addr),
        .wr_data (insn_wr_data),
        .rd_addr (pc[pc_w-1:0]),
        .rd_data (imem_data)
    );

    // nothing is fetched behind a halt
    assign fetch_insn = halt_seen ? nop_insn : pc[pc_w] ? halt_insn : imem_data;

    register_file u_register_file (
        .clk          (clk),
        .reset        (reset),
        .init_r0      (launch && init_r0_flag),
        .init_r0_data (init_r0_data),
        .rd_idx0      (fd_insn[src0_lsb +: reg_idx_w]),
        .rd_idx1      (fd_insn[src1_lsb +: reg_idx_w]),
        .rd_idx2      (fd_insn[src2_lsb +: reg_idx_w]),
        .rd_data0     (rf_a),
        .rd_data1     (rf_b),
        .rd_data2     (rf_c),
        .wr_en        (writes_reg(mw_op) && !freeze),
        .wr_idx       (mw_insn[dst_lsb +: reg_idx_w]),
        .wr_data      (mw_value)
    );

    hazard_unit u_hazard_unit (
        .dec_insn (fd_insn),
        .ex_insn  (dx_insn),
        .mem_insn (xm_insn),
        .wb_insn  (mw_insn),
        .stall    (stall),
        .fwd_sel0 (fwd_sel0),
        .fwd_sel1 (fwd_sel1),
        .fwd_sel2 (fwd_sel2)
    );

    assign ex_a = fwd_mux(fwd_sel0, dx_a, xm_result, mw_value);
    assign ex_b = fwd_mux(fwd_sel1, dx_b, xm_result, mw_value);
    assign ex_c = fwd_mux(fwd_sel2, dx_c, xm_result, mw_value);

    alu #(
        .core_id (core_id)
    ) u_alu (
        .opcode  (ex_op),
        .a       (ex_a),
        .b       (ex_b),
        .konst   (dx_insn[konst_lsb +: word_w]),
        .result  (alu_result),
        .nonzero (alu_nonzero)
    );

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ready_r <= 1'b1;
            pc <= '0;
        end
        else if (launch)
        begin
            ready_r <= 1'b0;
            pc <= '0;
        end
        else if (!freeze)
        begin
            if (halt_done)
                ready_r <= 1'b1;
            if (take_branch)
                pc <= {1'b0, dx_insn[target_lsb +: pc_w]};
            else if (!stall && !halt_seen)
                pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || launch || halt_done)
        begin
            fd_insn <= nop_insn;
            dx_insn <= nop_insn;
            xm_insn <= nop_insn;
            mw_insn <= nop_insn;  // its write lands at this edge
        end
        else if (!freeze)
        begin
            if (take_branch)
                fd_insn <= nop_insn;
            else if (!stall)
                fd_insn <= fetch_insn;
            dx_insn <= (stall || take_branch) ? nop_insn : fd_insn;
            xm_insn <= dx_insn;
            mw_insn <= xm_insn;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!freeze)
        begin
            dx_a <= rf_a;
            dx_b <= rf_b;
            dx_c <= rf_c;
            xm_result <= alu_result;
            xm_wdata <= ex_c;
            mw_value <= (xm_op == op_ld) ? mem_rdata : xm_result;
        end
    end

    assign ready = ready_r;
    assign mem_en = (xm_op == op_ld) ? mem_ld : (xm_op == op_st) ? mem_st : 2'b00;
    assign mem_addr = xm_result[addr_w-1:0];
    assign mem_wdata = xm_wdata;

    // an idle core makes no memory request
    a_idle_no_mem: assert property (@(posedge clk) disable iff (reset)
        ready_r |-> mem_en == 2'b00);

endmodule

// ==== logic/data_memory.sv ====
`timescale 1ns/10ps

module data_memory #(
    parameter int mem_wait = 2
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic [1:0]                   en,
    input  logic [core_pkg::addr_w-1:0]  addr,
    input  logic [core_pkg::word_w-1:0]  wdata,
    output logic [core_pkg::word_w-1:0]  rdata,
    output logic                         mem_ready,
    input  logic [core_pkg::addr_w-1:0]  dbg_addr,
    output logic [core_pkg::word_w-1:0]  dbg_data
);
    import core_pkg::*;

    localparam int cnt_w = $clog2(mem_wait + 2);

    logic [word_w-1:0] mem [2**addr_w];
    logic [cnt_w-1:0] wait_cnt;

    assign mem_ready = wait_cnt == cnt_w'(mem_wait);

    // restarts after every completed access
    always_ff @(posedge clk)
    begin
        if (reset)
            wait_cnt <= '0;
        else if (en != 2'b00 && !mem_ready)
            wait_cnt <= wait_cnt + 1'b1;
        else
            wait_cnt <= '0;
    end

    always_ff @(posedge clk)
    begin
        if (en == mem_st && mem_ready)
            mem[addr] <= wdata;
    end

    assign rdata = mem[addr];
    assign dbg_data = mem[dbg_addr];  // host read-back

    // the core freezes while it waits
    a_en_stable: assert property (@(posedge clk) disable iff (reset)
        (en != 2'b00 && !mem_ready) |=> en == $past(en));

endmodule

// ==== logic/core_system.sv ====
`timescale 1ns/10ps

module core_system #(
    parameter logic [7:0] core_id = 8'd0,
    parameter int mem_wait = 2
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          insn_wr,
    input  logic [core_pkg::pc_w-1:0]     insn_wr_addr,
    input  logic [core_pkg::insn_w-1:0]   insn_wr_data,
    input  logic                          init_r0_flag,
    input  logic [core_pkg::word_w-1:0]   init_r0_data,
    input  logic                          start,
    output logic                          ready,
    input  logic [core_pkg::addr_w-1:0]   dbg_addr,
    output logic [core_pkg::word_w-1:0]   dbg_data
);
    import core_pkg::*;

    logic [1:0] mem_en;
    logic [addr_w-1:0] mem_addr;
    logic [word_w-1:0] mem_wdata;
    logic [word_w-1:0] mem_rdata;
    logic mem_ready;

    core #(
        .core_id (core_id)
    ) u_core (
        .clk          (clk),
        .reset        (reset),
        .insn_wr      (insn_wr),
        .insn_wr_addr (insn_wr_addr),
        .insn_wr_data (insn_wr_data),
        .init_r0_flag (init_r0_flag),
        .init_r0_data (init_r0_data),
        .start        (start),
        .ready        (ready),
        .mem_en       (mem_en),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_ready    (mem_ready)
    );

    data_memory #(
        .mem_wait (mem_wait)
    ) u_data_memory (
        .clk       (clk),
        .reset     (reset),
        .en        (mem_en),
        .addr      (mem_addr),
        .wdata     (mem_wdata),
        .rdata     (mem_rdata),
        .mem_ready (mem_ready),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data)
    );

endmodule

// ==== tests/tb_core_system.sv ====
`timescale 1ns/10ps

module tb_core_system;
    import core_pkg::*;

    localparam logic [7:0] core_id = 8'd5;
    localparam int mem_wait = 2;
    localparam int clk_period = 20;
    localparam int n_tests = 6;
    localparam int watchdog_cycles = 400 * n_tests;
    localparam logic [opcode_w-1:0] rr_ops [9] = '{op_add, op_sub, op_mul, op_and, op_or,
        op_xor, op_shl, op_shr, op_cmpge};

    logic clk;
    logic reset;
    logic insn_wr;
    logic [pc_w-1:0] insn_wr_addr;
    logic [insn_w-1:0] insn_wr_data;
    logic init_r0_flag;
    logic [word_w-1:0] init_r0_data;
    logic start;
    logic ready;
    logic [addr_w-1:0] dbg_addr;
    logic [word_w-1:0] dbg_data;

    logic [insn_w-1:0] prog [$];  // program being built
    int touched [$];              // stored addresses to read back
    logic [word_w-1:0] m_reg [16];
    logic [word_w-1:0] m_mem [256];
    int n_mem;
    int errors;
    int checks;
    int tests_run;

    core_system #(.core_id(core_id), .mem_wait(mem_wait)) u_core_system (
        .clk(clk), .reset(reset), .insn_wr(insn_wr), .insn_wr_addr(insn_wr_addr),
        .insn_wr_data(insn_wr_data), .init_r0_flag(init_r0_flag),
        .init_r0_data(init_r0_data), .start(start), .ready(ready),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data)
    );

    always #(clk_period / 2) clk = ~clk;

    initial
    begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the core never finished", watchdog_cycles);
        $display("Simulation failed");
        $finish;
    end

    function automatic logic [insn_w-1:0] enc(input logic [opcode_w-1:0] op, input int d,
            input int s0, input int s1, input logic [word_w-1:0] low);
        return {op, reg_idx_w'(d), reg_idx_w'(s0), reg_idx_w'(s1), low};
    endfunction

    // ISA rules for the register ops
    function automatic logic [word_w-1:0] alu_ref(input logic [opcode_w-1:0] op,
            input logic [word_w-1:0] a, input logic [word_w-1:0] b);
        case (op)
            op_add:   return a + b;
            op_sub:   return a - b;
            op_mul:   return a * b;
            op_and:   return a & b;
            op_or:    return a | b;
            op_xor:   return a ^ b;
            op_shl:   return a << b[3:0];
            op_shr:   return a >> b[3:0];
            op_cmpge: return (a >= b) ? word_w'(1) : word_w'(0);
            default:  return '0;
        endcase
    endfunction

    task automatic emit_rr(input logic [opcode_w-1:0] op, input int d, input int a, input int b);
        prog.push_back(enc(op, d, a, b, '0));
        m_reg[d] = alu_ref(op, m_reg[a], m_reg[b]);
    endtask

    task automatic emit_setc(input int d, input logic [word_w-1:0] k);
        prog.push_back(enc(op_setc, d, 0, 0, k));
        m_reg[d] = k;
    endtask

    // r15 is never written, so it serves as a zero base
    task automatic emit_st(input int s, input int a);
        prog.push_back(enc(op_st, 0, 15, 0, {reg_idx_w'(s), 4'h0, addr_w'(a)}));
        m_mem[a] = m_reg[s];
        touched.push_back(a);
        n_mem++;
    endtask

    task automatic emit_ld(input int d, input int a);
        prog.push_back(enc(op_ld, d, 15, 0, {8'h00, addr_w'(a)}));
        m_reg[d] = m_mem[a];
        n_mem++;
    endtask

    task automatic check_word(input string name, input logic [word_w-1:0] got,
            input logic [word_w-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // load, start, wait for ready, then read back every stored word
    task automatic run_prog(input logic flag, input logic [word_w-1:0] r0_val, output int cycles);
        prog.push_back(enc(op_halt, 0, 0, 0, '0));
        foreach (prog[i])
        begin
            @(negedge clk);
            insn_wr = 1'b1;
            insn_wr_addr = pc_w'(i);
            insn_wr_data = prog[i];
        end
        @(negedge clk);
        insn_wr = 1'b0;
        init_r0_flag = flag;
        init_r0_data = r0_val;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        init_r0_flag = 1'b0;
        cycles = 1;
        while (!ready)
        begin
            @(negedge clk);
            cycles++;
        end
        foreach (touched[i])
        begin
            dbg_addr = addr_w'(touched[i]);
            @(posedge clk);
            check_word($sformatf("mem[%0d]", touched[i]), dbg_data, m_mem[touched[i]]);
            @(negedge clk);
        end
        prog.delete();
        touched.delete();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - errs_before);
    endtask

    task automatic test_chain();
        int e = errors;
        int cyc;
        emit_setc(1, 16'h1234);
        emit_setc(2, 16'h00f3);
        for (int k = 0; k < 9; k++)
            emit_rr(rr_ops[k], 3 + k, 2 + k, 1 + k % 2);  // previous result feeds the next
        for (int k = 0; k < 9; k++)
            emit_st(3 + k, k);
        run_prog(1'b0, '0, cyc);
        finish_test("dependent chain", e);
    endtask

    task automatic test_load_use();
        int e = errors;
        int cyc;
        emit_setc(1, 16'h0bad);
        emit_st(1, 40);
        emit_ld(2, 40);
        emit_rr(op_add, 3, 2, 1);
        emit_st(3, 41);
        run_prog(1'b0, '0, cyc);
        finish_test("load-use", e);
    endtask

    task automatic test_branch_loop();
        int e = errors;
        int cyc;
        int n = 10;
        int top;
        emit_setc(1, word_w'(n));
        emit_setc(2, '0);
        emit_setc(3, 16'd1);
        top = prog.size();
        prog.push_back(enc(op_add, 2, 2, 1, '0));
        prog.push_back(enc(op_sub, 1, 1, 3, '0));
        prog.push_back(enc(op_bnz, 0, 1, 0, word_w'(top)));
        m_reg[1] = '0;
        m_reg[2] = word_w'(n * (n + 1) / 2);
        emit_st(2, 20);
        run_prog(1'b0, '0, cyc);
        finish_test("branch loop", e);
    endtask

    task automatic test_init_and_id();
        int e = errors;
        int cyc;
        m_reg[0] = 16'h5a5a;
        emit_st(0, 50);
        prog.push_back(enc(op_setid, 4, 0, 0, '0));
        m_reg[4] = word_w'(core_id);
        emit_st(4, 51);
        run_prog(1'b1, 16'h5a5a, cyc);
        finish_test("host init and core id", e);
    endtask

    task automatic test_wait_states();
        int e = errors;
        int cyc;
        n_mem = 0;
        for (int k = 0; k < 4; k++)
        begin
            emit_setc(1 + k, word_w'(16'h1111 * (k + 1)));
            emit_st(1 + k, 60 + k);
            emit_ld(5 + k, 60 + k);
        end
        for (int k = 0; k < 4; k++)
            emit_st(5 + k, 70 + k);
        run_prog(1'b0, '0, cyc);
        if (cyc < n_mem * (mem_wait + 1))
        begin
            $display("ready rose after %0d cycles, before %0d memory accesses could finish",
                cyc, n_mem);
            errors++;
        end
        finish_test("memory wait states", e);
    endtask

    task automatic test_random_ops();
        int e = errors;
        int cyc;
        for (int p = 0; p < 20; p++)
        begin
            emit_setc(1, word_w'($urandom()));
            emit_setc(2, word_w'($urandom()));
            for (int k = 0; k < 9; k++)
                emit_rr(rr_ops[k], 3 + k, 1, 2);
            for (int k = 0; k < 9; k++)
                emit_st(3 + k, 100 + k);
            run_prog(1'b0, '0, cyc);
        end
        finish_test("random operands", e);
    endtask

    initial
    begin
        void'($urandom(83));
        clk = 1'b0;
        reset = 1'b1;
        insn_wr = 1'b0;
        insn_wr_addr = '0;
        insn_wr_data = '0;
        init_r0_flag = 1'b0;
        init_r0_data = '0;
        start = 1'b0;
        dbg_addr = '0;
        errors = 0;
        checks = 0;
        tests_run = 0;
        n_mem = 0;
        foreach (m_reg[i])
            m_reg[i] = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        check_bit("ready", ready, 1'b1);
        test_chain();
        test_load_use();
        test_branch_loop();
        test_init_and_id();
        test_wait_states();
        test_random_ops();
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== list.f ====
logic/core_pkg.sv
logic/insn_memory.sv
logic/register_file.sv
logic/alu.sv
logic/hazard_unit.sv
logic/core.sv
logic/data_memory.sv
logic/core_system.sv
tests/tb_core_system.sv

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, then decide by the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_core_system -f list.f \
    && ./obj_dir/Vtb_core_system | tee sim.log \
    || { echo "build or run error"; exit 1; }
grep -q "^Simulation completed successfully$" sim.log && exit 0 || exit 1
